/* arbiter/request_arbiter_n_to_1.sv */
/*
  Request arbiter, N to 1
  Each requester strobe is pushed into its own FIFO. A round-robin
  pointer pops one non-empty FIFO per cycle and the popped word is
  registered onto the single merged request stream.
*/
`timescale 1ns/10ps

module request_arbiter_n_to_1
  import glay_pkg::*;
(
  input  logic            ap_clk,
  input  logic            areset_control,
  input  memory_request_t request_in [NUM_MEMORY_RECEIVER-1:0],
  output memory_request_t request_out,
  output logic            fifo_setup_signal
);

  logic                           areset_int;
  request_payload_t               fifo_dout [NUM_MEMORY_RECEIVER];
  logic [NUM_MEMORY_RECEIVER-1:0] fifo_rd_en;
  logic [NUM_MEMORY_RECEIVER-1:0] fifo_empty;
  logic [NUM_MEMORY_RECEIVER-1:0] fifo_valid;
  logic [NUM_MEMORY_RECEIVER-1:0] fifo_wr_rst_busy;
  logic [NUM_MEMORY_RECEIVER-1:0] fifo_rd_rst_busy;
  logic [RR_PTR_W-1:0]            rr_ptr;
  logic [RR_PTR_W-1:0]            grant_idx;
  logic                           grant_any;
  request_payload_t               sel_payload;

  // Local reset copy
  always_ff @(posedge ap_clk) begin
    areset_int <= areset_control;
  end

  // ----------------------------------------
  // Per-requester FIFOs
  // ----------------------------------------
  for (genvar i = 0; i < NUM_MEMORY_RECEIVER; i++) begin : g_req_fifo
    assign fifo_rd_en[i] = grant_any & (int'(grant_idx) == i);

    sync_fifo #(
      .DEPTH      (REQ_FIFO_DEPTH),
      .WIDTH      ($bits(request_payload_t)),
      .PROG_THRESH(REQ_FIFO_DEPTH)
    ) u_fifo (
      .ap_clk     (ap_clk),
      .srst       (areset_int),
      .din        (request_in[i].payload),
      .wr_en      (request_in[i].valid),
      .rd_en      (fifo_rd_en[i]),
      .dout       (fifo_dout[i]),
      .full       (),
      .empty      (fifo_empty[i]),
      .valid      (fifo_valid[i]),
      .prog_full  (),
      .wr_rst_busy(fifo_wr_rst_busy[i]),
      .rd_rst_busy(fifo_rd_rst_busy[i])
    );
  end

  // ----------------------------------------
  // Round-robin grant
  // ----------------------------------------
  // Scan from rr_ptr; the nearest non-empty FIFO wins
  always_comb begin
    int cand;
    grant_any = 1'b0;
    grant_idx = rr_ptr;
    for (int k = NUM_MEMORY_RECEIVER - 1; k >= 0; k--) begin
      cand = int'(rr_ptr) + k;
      if (cand >= NUM_MEMORY_RECEIVER) begin
        cand = cand - NUM_MEMORY_RECEIVER;
      end
      if (!fifo_empty[cand]) begin
        grant_any = 1'b1;
        grant_idx = RR_PTR_W'(cand);
      end
    end
  end

  // Pointer moves past the granted input
  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      rr_ptr <= '0;
    end else if (grant_any) begin
      rr_ptr <= (int'(grant_idx) == NUM_MEMORY_RECEIVER - 1) ? '0 : grant_idx + 1'b1;
    end
  end

  // ----------------------------------------
  // Merged output
  // ----------------------------------------
  // At most one FIFO shows valid per cycle
  always_comb begin
    sel_payload = fifo_dout[0];
    for (int i = 1; i < NUM_MEMORY_RECEIVER; i++) begin
      if (fifo_valid[i]) begin
        sel_payload = fifo_dout[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      request_out.valid <= 1'b0;
      fifo_setup_signal <= 1'b1;
    end else begin
      request_out.valid <= |fifo_valid;
      fifo_setup_signal <= |(fifo_wr_rst_busy | fifo_rd_rst_busy);
    end
    request_out.payload <= sel_payload;
  end

endmodule : request_arbiter_n_to_1

/* arbiter/response_arbiter_1_to_n.sv */
/*
  Response arbiter, 1 to N
  Registers the single response stream, buffers it in a FIFO that the
  receivers drain with a level rd_en, and steers each popped response
  to the setup unit, the compute bundles, or both, by its source id.
*/
`timescale 1ns/10ps

module response_arbiter_1_to_n
  import glay_pkg::*;
(
  input  logic             ap_clk,
  input  logic             areset_control,
  input  memory_response_t response_in,
  input  fifo_state_in_t   fifo_response_signals_in,
  output fifo_state_out_t  fifo_response_signals_out,
  output memory_response_t response_out [NUM_MEMORY_RECEIVER-1:0],
  output logic             fifo_setup_signal
);

  // ----------------------------------------
  // Internal signals
  // ----------------------------------------
  logic              areset_int;
  memory_response_t  response_in_reg;
  logic              rd_en_reg;
  response_payload_t fifo_dout;
  logic              fifo_rd_en;
  logic              fifo_full;
  logic              fifo_empty;
  logic              fifo_valid;
  logic              fifo_prog_full;
  logic              fifo_wr_rst_busy;
  logic              fifo_rd_rst_busy;
  logic              to_setup;
  logic              to_bundles;

  // Local reset copy, also resets the FIFO
  always_ff @(posedge ap_clk) begin
    areset_int <= areset_control;
  end

  // ----------------------------------------
  // Input stage
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      response_in_reg.valid <= 1'b0;
      rd_en_reg             <= 1'b0;
    end else begin
      response_in_reg.valid <= response_in.valid;
      rd_en_reg             <= fifo_response_signals_in.rd_en;
    end
    response_in_reg.payload <= response_in.payload;
  end

  // ----------------------------------------
  // Response FIFO
  // ----------------------------------------
  // Pop while receivers are ready and data is there
  assign fifo_rd_en = rd_en_reg & ~fifo_empty;

  sync_fifo #(
    .DEPTH      (RSP_FIFO_DEPTH),
    .WIDTH      ($bits(response_payload_t)),
    .PROG_THRESH(RSP_PROG_THRESH)
  ) u_rsp_fifo (
    .ap_clk     (ap_clk),
    .srst       (areset_int),
    .din        (response_in_reg.payload),
    .wr_en      (response_in_reg.valid),
    .rd_en      (fifo_rd_en),
    .dout       (fifo_dout),
    .full       (fifo_full),
    .empty      (fifo_empty),
    .valid      (fifo_valid),
    .prog_full  (fifo_prog_full),
    .wr_rst_busy(fifo_wr_rst_busy),
    .rd_rst_busy(fifo_rd_rst_busy)
  );

  // FIFO state seen by the receivers
  always_ff @(posedge ap_clk) begin
    fifo_response_signals_out <= '{
      full:      fifo_full,
      empty:     fifo_empty,
      valid:     fifo_valid,
      prog_full: fifo_prog_full
    };
  end

  // Setup held high through reset and the FIFO busy window
  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      fifo_setup_signal <= 1'b1;
    end else begin
      fifo_setup_signal <= fifo_wr_rst_busy | fifo_rd_rst_busy;
    end
  end

  // ----------------------------------------
  // Routing
  // ----------------------------------------
  assign to_setup   = route_to_setup(fifo_dout.meta.source);
  assign to_bundles = route_to_bundles(fifo_dout.meta.source);

  // Receiver 0 is setup, receiver 1 the bundles
  // All-ones source lands on both
  always_ff @(posedge ap_clk) begin
    if (areset_int) begin
      response_out[0].valid <= 1'b0;
      response_out[1].valid <= 1'b0;
    end else begin
      response_out[0].valid <= fifo_valid & to_setup;
      response_out[1].valid <= fifo_valid & to_bundles;
    end
    response_out[0].payload <= fifo_dout;
    response_out[1].payload <= fifo_dout;
  end

endmodule : response_arbiter_1_to_n

/* common/glay_pkg.sv */
/*
  Memory channel shared definitions
  Widths, depths and FIFO settings for the request and response paths,
  the packet structs carried on both streams, FIFO state bundles, and
  the source-id routing rule used by the response arbiter.
*/
package glay_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int NUM_MEMORY_RECEIVER = 2;
  localparam int ADDR_W              = 8;
  localparam int DATA_W              = 32;
  localparam int ID_W                = 4;
  localparam int MEM_DEPTH           = 256;

  // FIFO depths and thresholds
  localparam int REQ_FIFO_DEPTH       = 16;
  localparam int RSP_FIFO_DEPTH       = 64;
  localparam int RSP_PROG_THRESH      = 32;
  localparam int FIFO_RST_BUSY_CYCLES = 4;

  // Reset-busy down counter
  localparam int                    RST_BUSY_W    = $clog2(FIFO_RST_BUSY_CYCLES + 1);
  localparam logic [RST_BUSY_W-1:0] RST_BUSY_INIT = RST_BUSY_W'(FIFO_RST_BUSY_CYCLES);

  // Round-robin pointer over the requesters
  localparam int RR_PTR_W = $clog2(NUM_MEMORY_RECEIVER);

  // Command encoding in the meta
  localparam logic CMD_READ  = 1'b0;
  localparam logic CMD_WRITE = 1'b1;

  // ----------------------------------------
  // Packets
  // ----------------------------------------
  typedef struct packed {
    logic [ID_W-1:0] id_cu;
    logic [ID_W-1:0] id_bundle;
    logic [ID_W-1:0] id_lane;
    logic [ID_W-1:0] id_engine;
  } packet_source_t;

  typedef struct packed {
    packet_source_t source;
    logic           cmd;
  } packet_meta_t;

  typedef struct packed {
    packet_meta_t      meta;
    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] data;
  } request_payload_t;

  typedef struct packed {
    logic             valid;
    request_payload_t payload;
  } memory_request_t;

  typedef struct packed {
    packet_meta_t      meta;
    logic [DATA_W-1:0] data;
  } response_payload_t;

  typedef struct packed {
    logic              valid;
    response_payload_t payload;
  } memory_response_t;

  // ----------------------------------------
  // FIFO state
  // ----------------------------------------
  typedef struct packed {
    logic rd_en;
  } fifo_state_in_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
  } fifo_state_out_t;

  // ----------------------------------------
  // Routing rule
  // ----------------------------------------
  // Setup unit takes all-zero and all-ones (broadcast) sources
  function automatic logic route_to_setup(packet_source_t src);
    return (&src) | ~(|src);
  endfunction

  // Compute bundles take any nonzero source
  function automatic logic route_to_bundles(packet_source_t src);
    return |src;
  endfunction

endpackage : glay_pkg

/* memory/memory_server.sv */
/*
  Memory server
  Flat word-addressed RAM behind the merged request stream. Writes
  store their data silently. Reads return the stored word one cycle
  later with the request meta copied, in request order.
*/
`timescale 1ns/10ps

module memory_server
  import glay_pkg::*;
(
  input  logic             ap_clk,
  input  logic             areset_control,
  input  memory_request_t  request_in,
  output memory_response_t response_out
);

  logic              areset_int;
  logic [DATA_W-1:0] ram [MEM_DEPTH];
  logic              is_write;
  logic              is_read;

  // Local reset copy
  always_ff @(posedge ap_clk) begin
    areset_int <= areset_control;
  end

  // ----------------------------------------
  // Command decode
  // ----------------------------------------
  assign is_write = request_in.valid & (request_in.payload.meta.cmd == CMD_WRITE);
  assign is_read  = request_in.valid & (request_in.payload.meta.cmd == CMD_READ);

  // ----------------------------------------
  // RAM and response
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    // Only reads produce a response
    if (areset_int) begin
      response_out.valid <= 1'b0;
    end else begin
      response_out.valid <= is_read;
    end
    if (is_write) begin
      ram[request_in.payload.address] <= request_in.payload.data;
    end
    // Meta travels back with the read data
    response_out.payload.meta <= request_in.payload.meta;
    response_out.payload.data <= ram[request_in.payload.address];
  end

endmodule : memory_server

/* run_sim.sh */
#!/bin/sh
# Build the memory channel testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module tb_memory_channel \
  -f verilog.f \
  -o sim_memory_channel

# Simulator status is judged from the log below
./obj_dir/sim_memory_channel > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
  echo "Simulation PASS"
else
  echo "Simulation FAIL"
  exit 1
fi

/* src/memory_channel_top.sv */
/*
  Memory channel top
  Request arbiter merges both requesters into the memory server, and
  the response arbiter returns read data to the setup unit and the
  compute bundles. Setup stays high while any FIFO leaves reset.
*/
`timescale 1ns/10ps

module memory_channel_top
  import glay_pkg::*;
(
  input  logic             ap_clk,
  input  logic             areset_control,
  input  memory_request_t  request_in [NUM_MEMORY_RECEIVER-1:0],
  input  fifo_state_in_t   fifo_response_signals_in,
  output fifo_state_out_t  fifo_response_signals_out,
  output memory_response_t response_out [NUM_MEMORY_RECEIVER-1:0],
  output logic             fifo_setup_signal
);

  memory_request_t  merged_request;
  memory_response_t server_response;
  logic             req_setup_signal;
  logic             rsp_setup_signal;

  // ----------------------------------------
  // Request path
  // ----------------------------------------
  request_arbiter_n_to_1 u_request_arbiter (
    .ap_clk           (ap_clk),
    .areset_control   (areset_control),
    .request_in       (request_in),
    .request_out      (merged_request),
    .fifo_setup_signal(req_setup_signal)
  );

  memory_server u_memory_server (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (merged_request),
    .response_out  (server_response)
  );

  // ----------------------------------------
  // Response path
  // ----------------------------------------
  response_arbiter_1_to_n u_response_arbiter (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .response_in              (server_response),
    .fifo_response_signals_in (fifo_response_signals_in),
    .fifo_response_signals_out(fifo_response_signals_out),
    .response_out             (response_out),
    .fifo_setup_signal        (rsp_setup_signal)
  );

  // Busy until both sides are out of reset
  assign fifo_setup_signal = req_setup_signal | rsp_setup_signal;

endmodule : memory_channel_top

/* src/sync_fifo.sv */
/*
  Synchronous FIFO
  Circular buffer with an occupancy count. A word written into an empty
  FIFO is readable in the same cycle. A read loads dout and raises valid
  one cycle later. After srst, pushes are held off for a short window
  that is reported on the reset-busy flags.
*/
`timescale 1ns/10ps

module sync_fifo
  import glay_pkg::*;
#(
  parameter int DEPTH       = 16,
  parameter int WIDTH       = 32,
  parameter int PROG_THRESH = 8
) (
  input  logic             ap_clk,
  input  logic             srst,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             valid,
  output logic             prog_full,
  output logic             wr_rst_busy,
  output logic             rd_rst_busy
);

  // Storage and pointers
  logic [WIDTH-1:0]           mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic [RST_BUSY_W-1:0]      busy_cnt;
  logic                       do_wr;
  logic                       do_rd;

  // ----------------------------------------
  // Flags
  // ----------------------------------------
  assign wr_rst_busy = (busy_cnt != '0);
  assign full        = (int'(count) == DEPTH);
  assign prog_full   = (int'(count) >= PROG_THRESH);

  // Pushes dropped while busy or full
  assign do_wr = wr_en & ~wr_rst_busy & ~full;
  // Incoming word counts as stored, read-through when empty
  assign empty = (count == '0) & ~do_wr;
  assign do_rd = rd_en & ~empty & ~rd_rst_busy;

  // ----------------------------------------
  // Control
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (srst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      valid       <= 1'b0;
      busy_cnt    <= RST_BUSY_INIT;
      rd_rst_busy <= 1'b1;
    end else begin
      if (busy_cnt != '0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      // Read side leaves busy one cycle after write side
      rd_rst_busy <= wr_rst_busy;
      valid       <= do_rd;
      if (do_wr) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------
  // Data
  // ----------------------------------------
  always_ff @(posedge ap_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    // Bypass the array when the word arrives in this cycle
    if (do_rd) begin
      dout <= (count == '0) ? din : mem[rd_ptr];
    end
  end

endmodule : sync_fifo

/* verification/tb_memory_channel.sv */
/*
  Memory channel testbench
  Directed tests on the channel top: reset and setup window, write then
  read, source routing, requester contention and response back-pressure.
*/
`timescale 1ns/10ps

module tb_memory_channel
  import glay_pkg::*;
();

  localparam int              WAIT_LIMIT   = 300;
  localparam int              QUIET_CYCLES = 12;
  localparam memory_request_t NO_REQUEST   = '0;

  logic             ap_clk;
  logic             areset_control;
  memory_request_t  request_in [NUM_MEMORY_RECEIVER-1:0];
  fifo_state_in_t   fifo_response_signals_in;
  fifo_state_out_t  fifo_response_signals_out;
  memory_response_t response_out [NUM_MEMORY_RECEIVER-1:0];
  logic             fifo_setup_signal;

  // Reference state
  logic [31:0]       lcg_state;
  logic [DATA_W-1:0] shadow_mem [MEM_DEPTH];
  logic [ADDR_W-1:0] written[$];
  memory_response_t  rx0_q[$];
  memory_response_t  rx1_q[$];
  memory_response_t  exp0_q[$];
  memory_response_t  exp1_q[$];
  memory_response_t  scoreboard [logic [15:0]];

  initial ap_clk = 1'b0;
  always #5 ap_clk = ~ap_clk;

  memory_channel_top u_dut (
    .ap_clk                   (ap_clk),
    .areset_control           (areset_control),
    .request_in               (request_in),
    .fifo_response_signals_in (fifo_response_signals_in),
    .fifo_response_signals_out(fifo_response_signals_out),
    .response_out             (response_out),
    .fifo_setup_signal        (fifo_setup_signal)
  );

  // Response capture on the falling edge where outputs are settled
  always @(negedge ap_clk) begin
    if (areset_control === 1'b0) begin
      if (response_out[0].valid === 1'b1) begin
        rx0_q.push_back(response_out[0]);
      end
      if (response_out[1].valid === 1'b1) begin
        rx1_q.push_back(response_out[1]);
      end
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic memory_request_t make_request(input logic cmd, input packet_source_t src,
                                                   input logic [ADDR_W-1:0] addr,
                                                   input logic [DATA_W-1:0] data);
    memory_request_t r;
    r.valid               = 1'b1;
    r.payload.meta.source = src;
    r.payload.meta.cmd    = cmd;
    r.payload.address     = addr;
    r.payload.data        = data;
    return r;
  endfunction

  // Read answer taken from the shadow copy of the RAM
  function automatic memory_response_t model_read(input packet_source_t src,
                                                  input logic [ADDR_W-1:0] addr);
    memory_response_t r;
    r.valid               = 1'b1;
    r.payload.meta.source = src;
    r.payload.meta.cmd    = CMD_READ;
    r.payload.data        = shadow_mem[addr];
    return r;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_response(input memory_response_t got, input memory_response_t exp,
                                input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_fifo_state(input fifo_state_out_t got, input fifo_state_out_t exp,
                                  input string what);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  // One request per port held for a single cycle
  task automatic drive_requests(input memory_request_t r0, input memory_request_t r1);
    @(negedge ap_clk);
    request_in[0] = r0;
    request_in[1] = r1;
  endtask

  task automatic idle_requests();
    @(negedge ap_clk);
    request_in[0].valid = 1'b0;
    request_in[1].valid = 1'b0;
  endtask

  // Expected copies go to every receiver the rule selects
  task automatic issue_read(input int port, input packet_source_t src,
                            input logic [ADDR_W-1:0] addr);
    memory_request_t req;
    req = make_request(CMD_READ, src, addr, '0);
    if (port == 0) begin
      drive_requests(req, NO_REQUEST);
    end else begin
      drive_requests(NO_REQUEST, req);
    end
    if (route_to_setup(src)) begin
      exp0_q.push_back(model_read(src, addr));
    end
    if (route_to_bundles(src)) begin
      exp1_q.push_back(model_read(src, addr));
    end
  endtask

  task automatic wait_setup_done();
    int cycles;
    cycles = 0;
    while (fifo_setup_signal !== 1'b0) begin
      @(negedge ap_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: fifo_setup_signal never fell after reset");
      end
    end
  endtask

  task automatic wait_responses(input int n0, input int n1);
    int cycles;
    cycles = 0;
    while (rx0_q.size() < n0 || rx1_q.size() < n1) begin
      @(posedge ap_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: expected responses did not all arrive");
      end
    end
  endtask

  // No stray or duplicate responses for a while
  task automatic expect_quiet();
    for (int i = 0; i < QUIET_CYCLES; i++) begin
      @(posedge ap_clk);
      if (rx0_q.size() != 0 || rx1_q.size() != 0) begin
        abort_run("Unexpected extra response on response_out");
      end
    end
  endtask

  task automatic collect_in_order();
    memory_response_t got;
    wait_responses(exp0_q.size(), exp1_q.size());
    while (exp0_q.size() > 0) begin
      got = rx0_q.pop_front();
      check_response(got, exp0_q.pop_front(), "response_out[0]");
    end
    while (exp1_q.size() > 0) begin
      got = rx1_q.pop_front();
      check_response(got, exp1_q.pop_front(), "response_out[1]");
    end
    expect_quiet();
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_reset();
    fifo_state_out_t idle_state;
    idle_state       = '0;
    idle_state.empty = 1'b1;
    // Local reset copies act on the second rising edge
    repeat (2) @(posedge ap_clk);
    @(negedge ap_clk);
    if (response_out[0].valid !== 1'b0 || response_out[1].valid !== 1'b0) begin
      abort_run("Response valid not low during reset");
    end
    if (fifo_setup_signal !== 1'b1) begin
      abort_run("fifo_setup_signal not high during reset");
    end
    areset_control = 1'b0;
    wait_setup_done();
    check_fifo_state(fifo_response_signals_out, idle_state, "FIFO state after setup");
  endtask

  // Nonzero mixed sources to the bundles only
  task automatic test_write_read();
    packet_source_t    src;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    for (int i = 0; i < 8; i++) begin
      addr = ADDR_W'(lcg_next() >> 16);
      data = lcg_next();
      src  = packet_source_t'({4'h1, 4'h2, 4'(i), 4'h3});
      drive_requests(NO_REQUEST, make_request(CMD_WRITE, src, addr, data));
      shadow_mem[addr] = data;
      written.push_back(addr);
    end
    idle_requests();
    for (int i = 0; i < 8; i++) begin
      issue_read(1, packet_source_t'({4'h2, 4'h1, 4'(i), 4'h7}), written[i]);
    end
    idle_requests();
    collect_in_order();
  endtask

  // All zeros, all ones and mixed sources from the setup requester
  task automatic test_routing();
    packet_source_t src_list [4];
    src_list[0] = packet_source_t'(16'h0000);
    src_list[1] = packet_source_t'(16'hFFFF);
    src_list[2] = packet_source_t'(16'h1234);
    src_list[3] = packet_source_t'(16'hF00F);
    for (int i = 0; i < 4; i++) begin
      issue_read(0, src_list[i], written[i]);
    end
    idle_requests();
    collect_in_order();
  endtask

  // Both ports every cycle and matched by source
  task automatic test_contention();
    packet_source_t   src0;
    packet_source_t   src1;
    memory_response_t got;
    logic [15:0]      key;
    for (int i = 0; i < 8; i++) begin
      src0 = packet_source_t'({4'h1, 4'h5, 4'(i), 4'hA});
      src1 = packet_source_t'({4'h2, 4'h5, 4'(i), 4'hA});
      scoreboard[src0] = model_read(src0, written[i]);
      scoreboard[src1] = model_read(src1, written[7 - i]);
      drive_requests(make_request(CMD_READ, src0, written[i], '0),
                     make_request(CMD_READ, src1, written[7 - i], '0));
    end
    idle_requests();
    wait_responses(0, 16);
    while (rx1_q.size() > 0) begin
      got = rx1_q.pop_front();
      key = got.payload.meta.source;
      if (!scoreboard.exists(key)) begin
        abort_run($sformatf("Unexpected or repeated response for source %h", key));
      end
      check_response(got, scoreboard[key], "response_out[1] under contention");
      scoreboard.delete(key);
    end
    expect_quiet();
  endtask

  task automatic test_back_pressure();
    fifo_state_out_t exp_state;
    int              cycles;
    @(negedge ap_clk);
    fifo_response_signals_in.rd_en = 1'b0;
    for (int i = 0; i < RSP_PROG_THRESH; i++) begin
      issue_read(1, packet_source_t'({4'h3, 4'(i >> 4), 4'(i), 4'h1}),
                 written[i % written.size()]);
    end
    idle_requests();
    // prog_full marks every read as stored
    cycles = 0;
    while (fifo_response_signals_out.prog_full !== 1'b1) begin
      @(negedge ap_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: prog_full never rose with rd_en held low");
      end
    end
    exp_state           = '0;
    exp_state.prog_full = 1'b1;
    check_fifo_state(fifo_response_signals_out, exp_state, "FIFO state under back-pressure");
    @(posedge ap_clk);
    if (rx0_q.size() != 0 || rx1_q.size() != 0) begin
      abort_run("Response delivered while rd_en was low");
    end
    @(negedge ap_clk);
    fifo_response_signals_in.rd_en = 1'b1;
    collect_in_order();
    cycles = 0;
    while (fifo_response_signals_out.empty !== 1'b1 ||
           fifo_response_signals_out.valid !== 1'b0) begin
      @(negedge ap_clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("Timeout: response FIFO did not return to empty");
      end
    end
    exp_state       = '0;
    exp_state.empty = 1'b1;
    check_fifo_state(fifo_response_signals_out, exp_state, "FIFO state after drain");
  endtask

  // ----------------------------------------
  // Sequence
  // ----------------------------------------
  initial begin
    lcg_state                      = 32'd71181;
    areset_control                 = 1'b1;
    request_in[0]                  = NO_REQUEST;
    request_in[1]                  = NO_REQUEST;
    fifo_response_signals_in.rd_en = 1'b1;
    test_reset();
    test_write_read();
    test_routing();
    test_contention();
    test_back_pressure();
    $display("Verification passed");
    $finish;
  end

endmodule : tb_memory_channel

/* verilog.f */
common/glay_pkg.sv
src/sync_fifo.sv
arbiter/request_arbiter_n_to_1.sv
arbiter/response_arbiter_1_to_n.sv
memory/memory_server.sv
src/memory_channel_top.sv
verification/tb_memory_channel.sv
